//--- src/aib_axi_pkg.sv
package aib_axi_pkg;

    // AXI field widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int RESP_W = 2;

    // One link payload word
    localparam int PAYLOAD_W = 36;

    // Credit counters and init-credit inputs
    localparam int CREDIT_W = 8;

    // Every receive FIFO has this depth, so no init credit may exceed it
    localparam int FIFO_DEPTH = 8;

    // Register stages per link direction
    localparam int LINK_DELAY = 4;

    localparam int NBR_FWD_CHAN = 3;
    localparam int NBR_RET_CHAN = 2;

    typedef enum logic [2:0] {
        CH_AR = 3'd0,
        CH_AW = 3'd1,
        CH_W  = 3'd2,
        CH_R  = 3'd3,
        CH_B  = 3'd4
    } chan_kind_e;

    // AR and AW
    typedef struct packed {
        logic [ADDR_W-1:0]           addr;
        logic [PAYLOAD_W-ADDR_W-1:0] pad;
    } addr_view_t;

    // W
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } wdata_view_t;

    // R, and B with data unused
    typedef struct packed {
        logic [DATA_W-1:0]                  data;
        logic [RESP_W-1:0]                  resp;
        logic [PAYLOAD_W-DATA_W-RESP_W-1:0] pad;
    } rdata_view_t;

    typedef union packed {
        addr_view_t  addr_view;
        wdata_view_t wdata_view;
        rdata_view_t rdata_view;
    } payload_u;

    // Credit bits always refer to the channels of the opposite direction
    typedef struct packed {
        logic       valid;
        chan_kind_e kind;
        payload_u   payload;
        logic [2:0] credit_ret;
    } link_flit_t;

endpackage

//--- src/chan_tx_arbiter.sv
`timescale 1ns/1ps

module chan_tx_arbiter #(
    parameter int                     NBR_CHAN  = aib_axi_pkg::NBR_FWD_CHAN,
    parameter aib_axi_pkg::chan_kind_e CHAN_BASE = aib_axi_pkg::CH_AR
) (
    input  logic                              i_clk_wr,
    input  logic                              i_rst_n,

    // User-side channel 0 maps to CHAN_BASE
    input  logic [NBR_CHAN-1:0]               i_valid,
    output logic [NBR_CHAN-1:0]               o_ready,
    input  aib_axi_pkg::payload_u             i_payload [NBR_CHAN],
    input  logic [aib_axi_pkg::CREDIT_W-1:0]  i_init_credit [NBR_CHAN],

    // Pop pulses from the local receive FIFOs
    input  logic [2:0]                        i_credit_ret,

    input  aib_axi_pkg::link_flit_t           i_peer_flit,
    output aib_axi_pkg::link_flit_t           o_flit
);

    localparam int IDX_W = (NBR_CHAN > 1) ? $clog2(NBR_CHAN) : 1;

    logic [aib_axi_pkg::CREDIT_W-1:0] outstanding_q [NBR_CHAN];
    logic [NBR_CHAN-1:0]              eligible;
    logic [NBR_CHAN-1:0]              grant;
    logic                             found;
    logic [IDX_W-1:0]                 win_idx;
    logic [IDX_W-1:0]                 last_q;

    logic                             valid_q;
    aib_axi_pkg::chan_kind_e          kind_q;
    aib_axi_pkg::payload_u            payload_q;
    logic [2:0]                       credit_q;

    // A channel may only send while the far FIFO still has room for it
    always_comb begin
        for (int i = 0; i < NBR_CHAN; i++) begin
            eligible[i] = i_valid[i] && (outstanding_q[i] < i_init_credit[i]);
        end
    end

    // Round-robin search starting just after the last winner
    always_comb begin
        int idx;
        grant   = '0;
        found   = 1'b0;
        win_idx = '0;
        for (int k = 1; k <= NBR_CHAN; k++) begin
            idx = int'(last_q) + k;
            if (idx >= NBR_CHAN) begin
                idx = idx - NBR_CHAN;
            end
            if (!found && eligible[idx]) begin
                found   = 1'b1;
                win_idx = IDX_W'(idx);
            end
        end
        if (found) begin
            grant[win_idx] = 1'b1;
        end
    end

    assign o_ready = grant;

    always_ff @(posedge i_clk_wr or negedge i_rst_n) begin
        if (!i_rst_n) begin
            last_q <= IDX_W'(NBR_CHAN - 1);
        end else if (found) begin
            last_q <= win_idx;
        end
    end

    // A win adds one and a returned credit from the far side takes one away
    always_ff @(posedge i_clk_wr or negedge i_rst_n) begin
        if (!i_rst_n) begin
            outstanding_q <= '{default: '0};
        end else begin
            for (int i = 0; i < NBR_CHAN; i++) begin
                outstanding_q[i] <= outstanding_q[i]
                                  + aib_axi_pkg::CREDIT_W'(grant[i])
                                  - aib_axi_pkg::CREDIT_W'(i_peer_flit.credit_ret[i]);
            end
        end
    end

    // Flit control
    always_ff @(posedge i_clk_wr or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q  <= 1'b0;
            kind_q   <= CHAN_BASE;
            credit_q <= '0;
        end else begin
            valid_q  <= found;
            credit_q <= i_credit_ret;
            if (found) begin
                kind_q <= aib_axi_pkg::chan_kind_e'(3'(CHAN_BASE) + 3'(win_idx));
            end
        end
    end

    always_ff @(posedge i_clk_wr) begin
        if (found) begin
            payload_q <= i_payload[win_idx];
        end
    end

    assign o_flit = '{
        valid:      valid_q,
        kind:       kind_q,
        payload:    payload_q,
        credit_ret: credit_q
    };

endmodule

//--- src/chan_rx_fifo.sv
`timescale 1ns/1ps

module chan_rx_fifo #(
    parameter aib_axi_pkg::chan_kind_e CHAN_KIND = aib_axi_pkg::CH_AR
) (
    input  logic                    i_clk_wr,
    input  logic                    i_rst_n,

    input  aib_axi_pkg::link_flit_t i_flit,

    // User side
    output logic                    o_valid,
    input  logic                    i_ready,
    output aib_axi_pkg::payload_u   o_payload,

    // One pulse per pop goes back to the far arbiter
    output logic                    o_credit_ret
);

    localparam int PTR_W = $clog2(aib_axi_pkg::FIFO_DEPTH);

    aib_axi_pkg::payload_u mem [aib_axi_pkg::FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             push;
    logic             pop;

    // Only flits of this channel kind land here
    assign push = i_flit.valid && (i_flit.kind == CHAN_KIND);
    assign pop  = o_valid && i_ready;

    assign o_valid      = (count_q != '0);
    assign o_payload    = mem[rd_ptr_q];
    assign o_credit_ret = pop;

    always_ff @(posedge i_clk_wr) begin
        if (push) begin
            mem[wr_ptr_q] <= i_flit.payload;
        end
    end

    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge i_clk_wr or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Credits keep the count at or below FIFO_DEPTH
    always_ff @(posedge i_clk_wr or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

endmodule

//--- src/emib_link.sv
`timescale 1ns/1ps

module emib_link (
    input  logic                    i_clk_wr,
    input  logic                    i_rst_n,

    // Leader to follower
    input  aib_axi_pkg::link_flit_t i_fwd_flit,
    output aib_axi_pkg::link_flit_t o_fwd_flit,

    // Follower to leader
    input  aib_axi_pkg::link_flit_t i_ret_flit,
    output aib_axi_pkg::link_flit_t o_ret_flit
);

    aib_axi_pkg::link_flit_t fwd_pipe_q [aib_axi_pkg::LINK_DELAY];
    aib_axi_pkg::link_flit_t ret_pipe_q [aib_axi_pkg::LINK_DELAY];

    // Several flits are in flight per direction
    always_ff @(posedge i_clk_wr or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fwd_pipe_q <= '{default: '0};
            ret_pipe_q <= '{default: '0};
        end else begin
            fwd_pipe_q[0] <= i_fwd_flit;
            ret_pipe_q[0] <= i_ret_flit;
            for (int i = 1; i < aib_axi_pkg::LINK_DELAY; i++) begin
                fwd_pipe_q[i] <= fwd_pipe_q[i-1];
                ret_pipe_q[i] <= ret_pipe_q[i-1];
            end
        end
    end

    assign o_fwd_flit = fwd_pipe_q[aib_axi_pkg::LINK_DELAY-1];
    assign o_ret_flit = ret_pipe_q[aib_axi_pkg::LINK_DELAY-1];

endmodule

//--- src/aib_axi_top.sv
`timescale 1ns/1ps

module aib_axi_top (
    input  logic                               i_clk_wr,
    input  logic                               i_rst_n,

    input  logic [aib_axi_pkg::CREDIT_W-1:0]   i_init_ar_credit,
    input  logic [aib_axi_pkg::CREDIT_W-1:0]   i_init_aw_credit,
    input  logic [aib_axi_pkg::CREDIT_W-1:0]   i_init_w_credit,
    input  logic [aib_axi_pkg::CREDIT_W-1:0]   i_init_r_credit,
    input  logic [aib_axi_pkg::CREDIT_W-1:0]   i_init_b_credit,

    // Leader user side
    input  logic                               i_m_ar_valid,
    output logic                               o_m_ar_ready,
    input  logic [aib_axi_pkg::ADDR_W-1:0]     i_m_ar_addr,
    input  logic                               i_m_aw_valid,
    output logic                               o_m_aw_ready,
    input  logic [aib_axi_pkg::ADDR_W-1:0]     i_m_aw_addr,
    input  logic                               i_m_w_valid,
    output logic                               o_m_w_ready,
    input  logic [aib_axi_pkg::DATA_W-1:0]     i_m_w_data,
    input  logic [aib_axi_pkg::STRB_W-1:0]     i_m_w_strb,
    output logic                               o_m_r_valid,
    input  logic                               i_m_r_ready,
    output logic [aib_axi_pkg::DATA_W-1:0]     o_m_r_data,
    output logic [aib_axi_pkg::RESP_W-1:0]     o_m_r_resp,
    output logic                               o_m_b_valid,
    input  logic                               i_m_b_ready,
    output logic [aib_axi_pkg::RESP_W-1:0]     o_m_b_resp,

    // Follower user side
    output logic                               o_s_ar_valid,
    input  logic                               i_s_ar_ready,
    output logic [aib_axi_pkg::ADDR_W-1:0]     o_s_ar_addr,
    output logic                               o_s_aw_valid,
    input  logic                               i_s_aw_ready,
    output logic [aib_axi_pkg::ADDR_W-1:0]     o_s_aw_addr,
    output logic                               o_s_w_valid,
    input  logic                               i_s_w_ready,
    output logic [aib_axi_pkg::DATA_W-1:0]     o_s_w_data,
    output logic [aib_axi_pkg::STRB_W-1:0]     o_s_w_strb,
    input  logic                               i_s_r_valid,
    output logic                               o_s_r_ready,
    input  logic [aib_axi_pkg::DATA_W-1:0]     i_s_r_data,
    input  logic [aib_axi_pkg::RESP_W-1:0]     i_s_r_resp,
    input  logic                               i_s_b_valid,
    output logic                               o_s_b_ready,
    input  logic [aib_axi_pkg::RESP_W-1:0]     i_s_b_resp
);

    aib_axi_pkg::payload_u            fwd_payload     [aib_axi_pkg::NBR_FWD_CHAN];
    aib_axi_pkg::payload_u            ret_payload     [aib_axi_pkg::NBR_RET_CHAN];
    logic [aib_axi_pkg::CREDIT_W-1:0] fwd_init_credit [aib_axi_pkg::NBR_FWD_CHAN];
    logic [aib_axi_pkg::CREDIT_W-1:0] ret_init_credit [aib_axi_pkg::NBR_RET_CHAN];
    logic [aib_axi_pkg::NBR_FWD_CHAN-1:0] fwd_ready;
    logic [aib_axi_pkg::NBR_RET_CHAN-1:0] ret_ready;

    // Pop pulses of R/B on the leader and of AR/AW/W on the follower
    logic [2:0] ldr_credit_ret;
    logic [2:0] fol_credit_ret;

    aib_axi_pkg::link_flit_t fwd_flit_tx;
    aib_axi_pkg::link_flit_t fwd_flit_rx;
    aib_axi_pkg::link_flit_t ret_flit_tx;
    aib_axi_pkg::link_flit_t ret_flit_rx;

    aib_axi_pkg::payload_u s_ar_payload;
    aib_axi_pkg::payload_u s_aw_payload;
    aib_axi_pkg::payload_u s_w_payload;
    aib_axi_pkg::payload_u m_r_payload;
    aib_axi_pkg::payload_u m_b_payload;

    // Pack leader requests into payload views
    assign fwd_payload[0].addr_view  = '{addr: i_m_ar_addr, pad: '0};
    assign fwd_payload[1].addr_view  = '{addr: i_m_aw_addr, pad: '0};
    assign fwd_payload[2].wdata_view = '{data: i_m_w_data, strb: i_m_w_strb};

    // B carries only a response
    assign ret_payload[0].rdata_view = '{data: i_s_r_data, resp: i_s_r_resp, pad: '0};
    assign ret_payload[1].rdata_view = '{data: '0, resp: i_s_b_resp, pad: '0};

    assign fwd_init_credit[0] = i_init_ar_credit;
    assign fwd_init_credit[1] = i_init_aw_credit;
    assign fwd_init_credit[2] = i_init_w_credit;
    assign ret_init_credit[0] = i_init_r_credit;
    assign ret_init_credit[1] = i_init_b_credit;

    assign o_m_ar_ready = fwd_ready[0];
    assign o_m_aw_ready = fwd_ready[1];
    assign o_m_w_ready  = fwd_ready[2];
    assign o_s_r_ready  = ret_ready[0];
    assign o_s_b_ready  = ret_ready[1];

    assign ldr_credit_ret[2] = 1'b0;

    chan_tx_arbiter #(
        .NBR_CHAN  (aib_axi_pkg::NBR_FWD_CHAN),
        .CHAN_BASE (aib_axi_pkg::CH_AR)
    ) ldr_arbiter_i (
        .i_clk_wr      (i_clk_wr),
        .i_rst_n       (i_rst_n),
        .i_valid       ({i_m_w_valid, i_m_aw_valid, i_m_ar_valid}),
        .o_ready       (fwd_ready),
        .i_payload     (fwd_payload),
        .i_init_credit (fwd_init_credit),
        .i_credit_ret  (ldr_credit_ret),
        .i_peer_flit   (ret_flit_rx),
        .o_flit        (fwd_flit_tx)
    );

    chan_tx_arbiter #(
        .NBR_CHAN  (aib_axi_pkg::NBR_RET_CHAN),
        .CHAN_BASE (aib_axi_pkg::CH_R)
    ) fol_arbiter_i (
        .i_clk_wr      (i_clk_wr),
        .i_rst_n       (i_rst_n),
        .i_valid       ({i_s_b_valid, i_s_r_valid}),
        .o_ready       (ret_ready),
        .i_payload     (ret_payload),
        .i_init_credit (ret_init_credit),
        .i_credit_ret  (fol_credit_ret),
        .i_peer_flit   (fwd_flit_rx),
        .o_flit        (ret_flit_tx)
    );

    emib_link emib_link_i (
        .i_clk_wr   (i_clk_wr),
        .i_rst_n    (i_rst_n),
        .i_fwd_flit (fwd_flit_tx),
        .o_fwd_flit (fwd_flit_rx),
        .i_ret_flit (ret_flit_tx),
        .o_ret_flit (ret_flit_rx)
    );

    // Follower receive side
    chan_rx_fifo #(.CHAN_KIND(aib_axi_pkg::CH_AR)) s_ar_fifo_i (
        .i_clk_wr     (i_clk_wr),
        .i_rst_n      (i_rst_n),
        .i_flit       (fwd_flit_rx),
        .o_valid      (o_s_ar_valid),
        .i_ready      (i_s_ar_ready),
        .o_payload    (s_ar_payload),
        .o_credit_ret (fol_credit_ret[0])
    );

    chan_rx_fifo #(.CHAN_KIND(aib_axi_pkg::CH_AW)) s_aw_fifo_i (
        .i_clk_wr     (i_clk_wr),
        .i_rst_n      (i_rst_n),
        .i_flit       (fwd_flit_rx),
        .o_valid      (o_s_aw_valid),
        .i_ready      (i_s_aw_ready),
        .o_payload    (s_aw_payload),
        .o_credit_ret (fol_credit_ret[1])
    );

    chan_rx_fifo #(.CHAN_KIND(aib_axi_pkg::CH_W)) s_w_fifo_i (
        .i_clk_wr     (i_clk_wr),
        .i_rst_n      (i_rst_n),
        .i_flit       (fwd_flit_rx),
        .o_valid      (o_s_w_valid),
        .i_ready      (i_s_w_ready),
        .o_payload    (s_w_payload),
        .o_credit_ret (fol_credit_ret[2])
    );

    // Leader receive side
    chan_rx_fifo #(.CHAN_KIND(aib_axi_pkg::CH_R)) m_r_fifo_i (
        .i_clk_wr     (i_clk_wr),
        .i_rst_n      (i_rst_n),
        .i_flit       (ret_flit_rx),
        .o_valid      (o_m_r_valid),
        .i_ready      (i_m_r_ready),
        .o_payload    (m_r_payload),
        .o_credit_ret (ldr_credit_ret[0])
    );

    chan_rx_fifo #(.CHAN_KIND(aib_axi_pkg::CH_B)) m_b_fifo_i (
        .i_clk_wr     (i_clk_wr),
        .i_rst_n      (i_rst_n),
        .i_flit       (ret_flit_rx),
        .o_valid      (o_m_b_valid),
        .i_ready      (i_m_b_ready),
        .o_payload    (m_b_payload),
        .o_credit_ret (ldr_credit_ret[1])
    );

    // Unpack payload views to AXI fields
    assign o_s_ar_addr = s_ar_payload.addr_view.addr;
    assign o_s_aw_addr = s_aw_payload.addr_view.addr;
    assign o_s_w_data  = s_w_payload.wdata_view.data;
    assign o_s_w_strb  = s_w_payload.wdata_view.strb;
    assign o_m_r_data  = m_r_payload.rdata_view.data;
    assign o_m_r_resp  = m_r_payload.rdata_view.resp;
    assign o_m_b_resp  = m_b_payload.rdata_view.resp;

endmodule

//--- dv/tb_aib_axi.sv
`timescale 1ns/1ps

module tb_aib_axi;

    localparam int TIMEOUT_CYCLES = 300;
    localparam int INIT_CREDIT    = 8;

    logic i_clk_wr;
    logic i_rst_n;
    logic [aib_axi_pkg::CREDIT_W-1:0] i_init_ar_credit, i_init_aw_credit, i_init_w_credit;
    logic [aib_axi_pkg::CREDIT_W-1:0] i_init_r_credit, i_init_b_credit;

    // Leader side
    logic                           i_m_ar_valid, i_m_aw_valid, i_m_w_valid;
    logic                           o_m_ar_ready, o_m_aw_ready, o_m_w_ready;
    logic [aib_axi_pkg::ADDR_W-1:0] i_m_ar_addr, i_m_aw_addr;
    logic [aib_axi_pkg::DATA_W-1:0] i_m_w_data, o_m_r_data;
    logic [aib_axi_pkg::STRB_W-1:0] i_m_w_strb;
    logic                           o_m_r_valid, i_m_r_ready, o_m_b_valid, i_m_b_ready;
    logic [aib_axi_pkg::RESP_W-1:0] o_m_r_resp, o_m_b_resp;

    // Follower side
    logic                           o_s_ar_valid, o_s_aw_valid, o_s_w_valid;
    logic                           i_s_ar_ready, i_s_aw_ready, i_s_w_ready;
    logic [aib_axi_pkg::ADDR_W-1:0] o_s_ar_addr, o_s_aw_addr;
    logic [aib_axi_pkg::DATA_W-1:0] o_s_w_data, i_s_r_data;
    logic [aib_axi_pkg::STRB_W-1:0] o_s_w_strb;
    logic                           i_s_r_valid, o_s_r_ready, i_s_b_valid, o_s_b_ready;
    logic [aib_axi_pkg::RESP_W-1:0] i_s_r_resp, i_s_b_resp;

    // Bits 38:36 hold the channel number (0 AR, 1 AW, 2 W, 3 R, 4 B)
    logic [38:0] exp_q [$];

    aib_axi_top aib_axi_top_i (.*);

    always #10 i_clk_wr = ~i_clk_wr;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check(input string name, input logic [35:0] got, input logic [35:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0t: %s = 0x%0h, expected 0x%0h",
                                      $time, name, got, exp));
        end
    endtask

    // Value holds the AR/AW addr, W {data, strb}, R {data, resp} or B resp
    task automatic drive(input int ch, input logic v, input logic [35:0] val);
        case (ch)
            0: begin
                i_m_ar_valid = v;
                i_m_ar_addr  = val[31:0];
            end
            1: begin
                i_m_aw_valid = v;
                i_m_aw_addr  = val[31:0];
            end
            2: begin
                i_m_w_valid = v;
                {i_m_w_data, i_m_w_strb} = val;
            end
            3: begin
                i_s_r_valid = v;
                {i_s_r_data, i_s_r_resp} = val[33:0];
            end
            default: begin
                i_s_b_valid = v;
                i_s_b_resp  = val[1:0];
            end
        endcase
    endtask

    function automatic logic ready_of(input int ch);
        case (ch)
            0: return o_m_ar_ready;
            1: return o_m_aw_ready;
            2: return o_m_w_ready;
            3: return o_s_r_ready;
            default: return o_s_b_ready;
        endcase
    endfunction

    // Starts just after a rising edge and returns just after the transfer edge
    task automatic send(input int ch, input logic [35:0] val);
        int n;
        n = 0;
        drive(ch, 1'b1, val);
        do begin
            @(negedge i_clk_wr);
            n++;
            if (n > TIMEOUT_CYCLES) begin
                stop_with_error($sformatf("Timeout: channel %0d never became ready", ch));
            end
        end while (!ready_of(ch));
        @(posedge i_clk_wr);
        #1;
        drive(ch, 1'b0, val);
    endtask

    task automatic expect_item(input int ch, input logic [35:0] val);
        exp_q.push_back({3'(ch), val});
    endtask

    // Oldest expected item of the same channel
    task automatic observe(input int ch, input string name, input logic [35:0] val);
        int idx;
        idx = -1;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (idx < 0 && exp_q[i][38:36] == 3'(ch)) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            stop_with_error($sformatf("Unexpected transfer on %s at %0t", name, $time));
        end else begin
            check(name, val, exp_q[idx][35:0]);
            exp_q.delete(idx);
        end
    endtask

    // Transfers are sampled mid-cycle away from the clock edge
    always @(negedge i_clk_wr) begin
        if (o_s_ar_valid && i_s_ar_ready) observe(0, "o_s_ar_addr", 36'(o_s_ar_addr));
        if (o_s_aw_valid && i_s_aw_ready) observe(1, "o_s_aw_addr", 36'(o_s_aw_addr));
        if (o_s_w_valid && i_s_w_ready) observe(2, "o_s_w_data/strb", {o_s_w_data, o_s_w_strb});
        if (o_m_r_valid && i_m_r_ready) begin
            observe(3, "o_m_r_data/resp", {2'b00, o_m_r_data, o_m_r_resp});
        end
        if (o_m_b_valid && i_m_b_ready) observe(4, "o_m_b_resp", 36'(o_m_b_resp));
    end

    // Idle afterwards so returned credits reach the arbiters
    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(negedge i_clk_wr);
            n++;
            if (n > TIMEOUT_CYCLES) begin
                stop_with_error($sformatf("Timeout: %0d expected items missing", exp_q.size()));
            end
        end
        repeat (12) @(posedge i_clk_wr);
        #1;
    endtask

    task automatic test_reset_state();
        @(negedge i_clk_wr);
        check("o_m_r_valid", 36'(o_m_r_valid), 36'd0);
        check("o_m_b_valid", 36'(o_m_b_valid), 36'd0);
        check("o_s_ar_valid", 36'(o_s_ar_valid), 36'd0);
        check("o_s_aw_valid", 36'(o_s_aw_valid), 36'd0);
        check("o_s_w_valid", 36'(o_s_w_valid), 36'd0);
        for (int ch = 0; ch < 5; ch++) begin
            check($sformatf("ready of channel %0d", ch), 36'(ready_of(ch)), 36'd0);
        end
        @(posedge i_clk_wr);
        #1;
    endtask

    task automatic test_read_round_trip();
        logic [35:0] addr;
        logic [35:0] rsp;
        addr = 36'($urandom);
        rsp  = {2'b00, $urandom, 2'($urandom)};
        expect_item(0, addr);
        send(0, addr);
        wait_drain();
        // Follower memory answers the read
        expect_item(3, rsp);
        send(3, rsp);
        wait_drain();
    endtask

    task automatic test_write_round_trip();
        logic [35:0] aw;
        logic [35:0] w;
        logic [35:0] resp;
        for (int i = 0; i < 3; i++) begin
            aw = 36'($urandom);
            w  = {$urandom, 4'($urandom)};
            expect_item(1, aw);
            expect_item(2, w);
            fork
                send(1, aw);
                send(2, w);
            join
        end
        wait_drain();
        for (int i = 0; i < 3; i++) begin
            resp = 36'(2'($urandom));
            expect_item(4, resp);
            send(4, resp);
        end
        wait_drain();
    endtask

    task automatic test_shared_order();
        fork
            begin
                logic [35:0] a;
                for (int i = 0; i < 12; i++) begin
                    a = 36'($urandom);
                    expect_item(0, a);
                    send(0, a);
                end
            end
            begin
                logic [35:0] d;
                for (int i = 0; i < 12; i++) begin
                    d = {$urandom, 4'($urandom)};
                    expect_item(2, d);
                    send(2, d);
                end
            end
        join
        wait_drain();
    endtask

    task automatic test_ar_backpressure();
        logic [35:0] addr [4];
        logic [35:0] w;
        int accepted;
        accepted = 0;
        i_init_ar_credit = 8'd2;
        i_s_ar_ready     = 1'b0;
        foreach (addr[i]) begin
            addr[i] = 36'($urandom);
            expect_item(0, addr[i]);
        end
        w = {$urandom, 4'($urandom)};
        expect_item(2, w);
        fork
            begin
                drive(0, 1'b1, addr[0]);
                repeat (50) begin
                    @(negedge i_clk_wr);
                    if (o_m_ar_ready) begin
                        accepted++;
                    end
                    @(posedge i_clk_wr);
                    #1;
                    if (accepted < 4) begin
                        drive(0, 1'b1, addr[accepted]);
                    end else begin
                        drive(0, 1'b0, addr[3]);
                    end
                end
            end
            // W keeps flowing while AR is stalled
            send(2, w);
        join
        check("AR transfers with 2 credits", 36'(accepted), 36'd2);
        check("items still pending", 36'(exp_q.size()), 36'd4);
        i_s_ar_ready = 1'b1;
        send(0, addr[2]);
        send(0, addr[3]);
        wait_drain();
        i_init_ar_credit = 8'(INIT_CREDIT);
    endtask

    task automatic test_return_credit();
        logic [35:0] r0;
        logic [35:0] r1;
        i_init_r_credit = 8'd1;
        i_m_r_ready     = 1'b0;
        r0 = {2'b00, $urandom, 2'($urandom)};
        r1 = {2'b00, $urandom, 2'($urandom)};
        expect_item(3, r0);
        expect_item(3, r1);
        send(3, r0);
        drive(3, 1'b1, r1);
        // Single credit stays out while the leader holds its R
        repeat (30) begin
            @(negedge i_clk_wr);
            check("o_s_r_ready", 36'(o_s_r_ready), 36'd0);
        end
        @(posedge i_clk_wr);
        #1;
        i_m_r_ready = 1'b1;
        send(3, r1);
        wait_drain();
        i_init_r_credit = 8'(INIT_CREDIT);
    endtask

    initial begin
        void'($urandom(79));
        i_clk_wr         = 1'b0;
        i_rst_n          = 1'b0;
        i_init_ar_credit = 8'(INIT_CREDIT);
        i_init_aw_credit = 8'(INIT_CREDIT);
        i_init_w_credit  = 8'(INIT_CREDIT);
        i_init_r_credit  = 8'(INIT_CREDIT);
        i_init_b_credit  = 8'(INIT_CREDIT);
        for (int ch = 0; ch < 5; ch++) begin
            drive(ch, 1'b0, 36'd0);
        end
        i_m_r_ready  = 1'b1;
        i_m_b_ready  = 1'b1;
        i_s_ar_ready = 1'b1;
        i_s_aw_ready = 1'b1;
        i_s_w_ready  = 1'b1;
        repeat (8) @(posedge i_clk_wr);
        #1;
        i_rst_n = 1'b1;
        test_reset_state();
        test_read_round_trip();
        test_write_round_trip();
        test_shared_order();
        test_ar_backpressure();
        test_return_credit();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- tb.f
src/aib_axi_pkg.sv
src/chan_tx_arbiter.sv
src/chan_rx_fifo.sv
src/emib_link.sv
src/aib_axi_top.sv
dv/tb_aib_axi.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f tb.f \
    --top-module tb_aib_axi \
    -Mdir obj_dir \
    -o sim_tb_aib_axi

./obj_dir/sim_tb_aib_axi
